/* Makefile */
VERILATOR ?= verilator
TOP       ?= csr_file_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' list.f)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) list.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f list.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/csr_access.sv */
`timescale 1ns/10ps

module csr_access (
    input  csr_pkg::csr_req_t req,
    input  logic [31:0]       mstatus,
    input  logic [31:0]       mtvec,
    input  logic [31:0]       mepc,
    input  logic [31:0]       mcause,
    input  logic [31:0]       mtval,
    input  logic [31:0]       mscratch,
    input  logic [31:0]       mie_csr,
    input  logic [31:0]       mip_csr,
    output logic [31:0]       rdata,
    output logic              illegal,
    output logic              wr_mstatus,
    output logic              wr_trap,
    output logic              wr_irq,
    output logic [2:0]        trap_sel,
    output logic [31:0]       wr_value
);

    logic known;
    logic read_only;
    logic is_trap;
    logic write_req;
    logic wr_en;

    // One decode gives the read value, the group and the access rights
    always_comb begin
        rdata     = 32'h0;
        known     = 1'b1;
        read_only = 1'b0;
        is_trap   = 1'b0;
        trap_sel  = csr_pkg::trap_sel_mtvec;
        case (req.addr)
            csr_pkg::csr_mstatus: rdata = mstatus;
            csr_pkg::csr_misa: begin
                rdata     = csr_pkg::misa_val;
                read_only = 1'b1;
            end
            csr_pkg::csr_mie: rdata = mie_csr;
            csr_pkg::csr_mtvec: begin
                rdata   = mtvec;
                is_trap = 1'b1;
            end
            csr_pkg::csr_mscratch: begin
                rdata    = mscratch;
                is_trap  = 1'b1;
                trap_sel = csr_pkg::trap_sel_mscratch;
            end
            csr_pkg::csr_mepc: begin
                rdata    = mepc;
                is_trap  = 1'b1;
                trap_sel = csr_pkg::trap_sel_mepc;
            end
            csr_pkg::csr_mcause: begin
                rdata    = mcause;
                is_trap  = 1'b1;
                trap_sel = csr_pkg::trap_sel_mcause;
            end
            csr_pkg::csr_mtval: begin
                rdata    = mtval;
                is_trap  = 1'b1;
                trap_sel = csr_pkg::trap_sel_mtval;
            end
            // Pending bits come from the platform lines only
            csr_pkg::csr_mip: begin
                rdata     = mip_csr;
                read_only = 1'b1;
            end
            csr_pkg::csr_mhartid: begin
                rdata     = csr_pkg::mhartid_val;
                read_only = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    // CSRRS and CSRRC with a zero operand are pure reads
    assign write_req = req.valid &&
                       ((req.op == csr_pkg::op_rw) || (req.wdata != 32'h0));

    assign illegal = req.valid && (!known || (read_only && write_req));
    assign wr_en   = write_req && !illegal;

    // Read-modify-write on the old value, masking is left to each register block
    always_comb begin
        case (req.op)
            csr_pkg::op_rw: wr_value = req.wdata;
            csr_pkg::op_rs: wr_value = rdata | req.wdata;
            csr_pkg::op_rc: wr_value = rdata & ~req.wdata;
            default:        wr_value = rdata;
        endcase
    end

    assign wr_mstatus = wr_en && (req.addr == csr_pkg::csr_mstatus);
    assign wr_trap    = wr_en && is_trap;
    assign wr_irq     = wr_en && (req.addr == csr_pkg::csr_mie);

endmodule

/* design/csr_file.sv */
`timescale 1ns/10ps

module csr_file (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::csr_req_t   req,
    input  csr_pkg::exc_t       exc,
    input  logic                irq_ack,
    input  logic                mret,
    input  logic [31:0]         irq_epc,
    input  csr_pkg::irq_lines_t irq,
    output logic [31:0]         rdata,
    output logic [31:0]         trap_target,
    output logic [31:0]         mret_target,
    output logic                illegal,
    output logic                irq_pending,
    output logic [1:0]          priv_mode
);

    // Architectural CSR values fed back into the read multiplexer
    logic [31:0] mstatus;
    logic [31:0] mtvec;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [31:0] mscratch;
    logic [31:0] mie_csr;
    logic [31:0] mip_csr;
    // Write strobes and data from the access decoder
    logic        wr_mstatus;
    logic        wr_trap;
    logic        wr_irq;
    logic [2:0]  trap_sel;
    logic [31:0] wr_value;
    // Cross-block trap and interrupt signals
    logic        trap_taken;
    logic        mie_bit;
    logic [30:0] irq_cause;

    csr_access u_access (
        .req        (req),
        .mstatus    (mstatus),
        .mtvec      (mtvec),
        .mepc       (mret_target),
        .mcause     (mcause),
        .mtval      (mtval),
        .mscratch   (mscratch),
        .mie_csr    (mie_csr),
        .mip_csr    (mip_csr),
        .rdata      (rdata),
        .illegal    (illegal),
        .wr_mstatus (wr_mstatus),
        .wr_trap    (wr_trap),
        .wr_irq     (wr_irq),
        .trap_sel   (trap_sel),
        .wr_value   (wr_value)
    );

    mstatus_reg u_mstatus (
        .clk        (clk),
        .rst_n      (rst_n),
        .trap_taken (trap_taken),
        .mret       (mret),
        .wr_mstatus (wr_mstatus),
        .wr_value   (wr_value),
        .mstatus    (mstatus),
        .mie_bit    (mie_bit),
        .priv_mode  (priv_mode)
    );

    // MRET returns to mepc, so the register drives the return target directly
    trap_regs u_trap (
        .clk         (clk),
        .rst_n       (rst_n),
        .exc         (exc),
        .irq_ack     (irq_ack),
        .irq_epc     (irq_epc),
        .irq_cause   (irq_cause),
        .wr_trap     (wr_trap),
        .trap_sel    (trap_sel),
        .wr_value    (wr_value),
        .trap_taken  (trap_taken),
        .mtvec       (mtvec),
        .mepc        (mret_target),
        .mcause      (mcause),
        .mtval       (mtval),
        .mscratch    (mscratch),
        .trap_target (trap_target)
    );

    interrupt_ctrl u_irq (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq         (irq),
        .wr_irq      (wr_irq),
        .wr_value    (wr_value),
        .mie_bit     (mie_bit),
        .mie_csr     (mie_csr),
        .mip_csr     (mip_csr),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause)
    );

endmodule

/* design/csr_pkg.sv */
package csr_pkg;

    // Machine-level CSR addresses
    localparam logic [11:0] csr_mstatus  = 12'h300;
    localparam logic [11:0] csr_misa     = 12'h301;
    localparam logic [11:0] csr_mie      = 12'h304;
    localparam logic [11:0] csr_mtvec    = 12'h305;
    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_mepc     = 12'h341;
    localparam logic [11:0] csr_mcause   = 12'h342;
    localparam logic [11:0] csr_mtval    = 12'h343;
    localparam logic [11:0] csr_mip      = 12'h344;
    localparam logic [11:0] csr_mhartid  = 12'hF14;

    // Privilege mode encodings as they appear in MPP
    localparam logic [1:0] mode_machine    = 2'b11;
    localparam logic [1:0] mode_supervisor = 2'b01;
    localparam logic [1:0] mode_user       = 2'b00;

    // Bit positions of the mstatus fields that this hart keeps
    localparam int mstatus_uie_pos    = 0;
    localparam int mstatus_sie_pos    = 1;
    localparam int mstatus_mie_pos    = 3;
    localparam int mstatus_upie_pos   = 4;
    localparam int mstatus_spie_pos   = 5;
    localparam int mstatus_mpie_pos   = 7;
    localparam int mstatus_spp_pos    = 8;
    localparam int mstatus_mpp_lo_pos = 11;

    // Interrupt bit positions shared by mie and mip
    localparam int irq_msi_pos = 3;
    localparam int irq_mti_pos = 7;
    localparam int irq_mei_pos = 11;

    // Write masks and constant CSR values
    localparam logic [31:0] mstatus_wmask     = 32'h0000_19BB;
    localparam logic [31:0] mstatus_reset_val = 32'h0000_1808;
    localparam logic [31:0] mtvec_wmask       = 32'hFFFF_FFFD;
    localparam logic [31:0] mepc_wmask        = 32'hFFFF_FFFC;
    localparam logic [31:0] mie_wmask         = 32'h0000_0888;
    localparam logic [31:0] mip_wmask         = 32'h0000_0000;
    // MXL of 1 selects a 32-bit hart and bit 8 is the base integer ISA
    localparam logic [31:0] misa_val          = 32'h4000_0100;
    localparam logic [31:0] mhartid_val       = 32'h0000_0000;

    // Interrupt cause codes without the interrupt flag
    localparam logic [30:0] cause_msi = 31'd3;
    localparam logic [30:0] cause_mti = 31'd7;
    localparam logic [30:0] cause_mei = 31'd11;

    // Select codes for the trap register group
    localparam logic [2:0] trap_sel_mtvec    = 3'd0;
    localparam logic [2:0] trap_sel_mepc     = 3'd1;
    localparam logic [2:0] trap_sel_mcause   = 3'd2;
    localparam logic [2:0] trap_sel_mtval    = 3'd3;
    localparam logic [2:0] trap_sel_mscratch = 3'd4;

    typedef enum logic [1:0] {
        op_rw,
        op_rs,
        op_rc
    } csr_op_t;

    typedef struct packed {
        logic        valid;
        csr_op_t     op;
        logic [11:0] addr;
        logic [31:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic        raise;
        logic [30:0] cause;
        logic [31:0] epc;
        logic [31:0] tval;
    } exc_t;

    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } irq_lines_t;

endpackage

/* design/interrupt_ctrl.sv */
`timescale 1ns/10ps

module interrupt_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  csr_pkg::irq_lines_t irq,
    input  logic                wr_irq,
    input  logic [31:0]         wr_value,
    input  logic                mie_bit,
    output logic [31:0]         mie_csr,
    output logic [31:0]         mip_csr,
    output logic                irq_pending,
    output logic [30:0]         irq_cause
);

    logic [31:0] hit;

    // Enables are written by software, pending bits follow the platform lines
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mie_csr <= 32'h0;
            mip_csr <= 32'h0;
        end else begin
            if (wr_irq) begin
                mie_csr <= wr_value & csr_pkg::mie_wmask;
            end
            mip_csr <= 32'h0;
            mip_csr[csr_pkg::irq_mei_pos] <= irq.meip;
            mip_csr[csr_pkg::irq_mti_pos] <= irq.mtip;
            mip_csr[csr_pkg::irq_msi_pos] <= irq.msip;
        end
    end

    assign hit         = mip_csr & mie_csr;
    assign irq_pending = mie_bit && (hit != 32'h0);

    // External first, then software, then timer
    always_comb begin
        if (hit[csr_pkg::irq_mei_pos]) begin
            irq_cause = csr_pkg::cause_mei;
        end else if (hit[csr_pkg::irq_msi_pos]) begin
            irq_cause = csr_pkg::cause_msi;
        end else begin
            irq_cause = csr_pkg::cause_mti;
        end
    end

endmodule

/* design/mstatus_reg.sv */
`timescale 1ns/10ps

module mstatus_reg (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        trap_taken,
    input  logic        mret,
    input  logic        wr_mstatus,
    input  logic [31:0] wr_value,
    output logic [31:0] mstatus,
    output logic        mie_bit,
    output logic [1:0]  priv_mode
);

    // Global interrupt enables for each privilege level
    logic       uie;
    logic       sie;
    logic       mie;
    // Interrupt enables saved on trap entry
    logic       upie;
    logic       spie;
    logic       mpie;
    // Previous privilege modes saved on trap entry
    logic       spp;
    logic [1:0] mpp;
    logic [31:0] wr_masked;

    // Only the architecturally writable bits reach the fields
    assign wr_masked = wr_value & csr_pkg::mstatus_wmask;

    // A trap wins over MRET, and both win over a CSR write in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uie      <= csr_pkg::mstatus_reset_val[csr_pkg::mstatus_uie_pos];
            sie      <= csr_pkg::mstatus_reset_val[csr_pkg::mstatus_sie_pos];
            mie      <= csr_pkg::mstatus_reset_val[csr_pkg::mstatus_mie_pos];
            upie     <= csr_pkg::mstatus_reset_val[csr_pkg::mstatus_upie_pos];
            spie     <= csr_pkg::mstatus_reset_val[csr_pkg::mstatus_spie_pos];
            mpie     <= csr_pkg::mstatus_reset_val[csr_pkg::mstatus_mpie_pos];
            spp      <= csr_pkg::mstatus_reset_val[csr_pkg::mstatus_spp_pos];
            mpp      <= csr_pkg::mstatus_reset_val[csr_pkg::mstatus_mpp_lo_pos +: 2];
        end else if (trap_taken) begin
            // Trap entry saves MIE and the current mode, which is always machine,
            // then masks interrupts
            mpp      <= csr_pkg::mode_machine;
            mpie     <= mie;
            mie      <= 1'b0;
        end else if (mret) begin
            // User and supervisor are not built, so MRET stays in machine mode
            mie      <= mpie;
            mpie     <= 1'b1;
        end else if (wr_mstatus) begin
            uie  <= wr_masked[csr_pkg::mstatus_uie_pos];
            sie  <= wr_masked[csr_pkg::mstatus_sie_pos];
            mie  <= wr_masked[csr_pkg::mstatus_mie_pos];
            upie <= wr_masked[csr_pkg::mstatus_upie_pos];
            spie <= wr_masked[csr_pkg::mstatus_spie_pos];
            mpie <= wr_masked[csr_pkg::mstatus_mpie_pos];
            spp  <= wr_masked[csr_pkg::mstatus_spp_pos];
            mpp  <= wr_masked[csr_pkg::mstatus_mpp_lo_pos +: 2];
        end
    end

    // SD, TSR, TW, TVM, MXR, SUM, MPRV, XS and FS are hardwired to zero on this hart
    always_comb begin
        mstatus = 32'h0;
        mstatus[csr_pkg::mstatus_uie_pos]       = uie;
        mstatus[csr_pkg::mstatus_sie_pos]       = sie;
        mstatus[csr_pkg::mstatus_mie_pos]       = mie;
        mstatus[csr_pkg::mstatus_upie_pos]      = upie;
        mstatus[csr_pkg::mstatus_spie_pos]      = spie;
        mstatus[csr_pkg::mstatus_mpie_pos]      = mpie;
        mstatus[csr_pkg::mstatus_spp_pos]       = spp;
        mstatus[csr_pkg::mstatus_mpp_lo_pos +: 2] = mpp;
    end

    assign mie_bit   = mie;
    // The hart never runs below machine mode, through traps and returns alike
    assign priv_mode = csr_pkg::mode_machine;

endmodule

/* design/trap_regs.sv */
`timescale 1ns/10ps

module trap_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::exc_t      exc,
    input  logic               irq_ack,
    input  logic [31:0]        irq_epc,
    input  logic [30:0]        irq_cause,
    input  logic               wr_trap,
    input  logic [2:0]         trap_sel,
    input  logic [31:0]        wr_value,
    output logic               trap_taken,
    output logic [31:0]        mtvec,
    output logic [31:0]        mepc,
    output logic [31:0]        mcause,
    output logic [31:0]        mtval,
    output logic [31:0]        mscratch,
    output logic [31:0]        trap_target
);

    logic [31:0] trap_epc;
    logic [31:0] trap_cause;
    logic [31:0] trap_tval;
    logic [31:0] tvec_base;
    logic [31:0] vec_offset;

    // Exceptions and accepted interrupts share one trap entry path
    assign trap_taken = exc.raise | irq_ack;

    // Values captured on trap entry, with the exception taking the lead
    always_comb begin
        if (exc.raise) begin
            trap_epc   = exc.epc;
            trap_cause = {1'b0, exc.cause};
            trap_tval  = exc.tval;
        end else begin
            trap_epc   = irq_epc;
            trap_cause = {1'b1, irq_cause};
            // Interrupts carry no faulting address or instruction
            trap_tval  = 32'h0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtvec    <= 32'h0;
            mepc     <= 32'h0;
            mcause   <= 32'h0;
            mtval    <= 32'h0;
            mscratch <= 32'h0;
        end else if (trap_taken) begin
            // The trapping instruction is dropped, so its CSR write goes too
            mepc   <= trap_epc & csr_pkg::mepc_wmask;
            mcause <= trap_cause;
            mtval  <= trap_tval;
        end else if (wr_trap) begin
            case (trap_sel)
                csr_pkg::trap_sel_mtvec:    mtvec    <= wr_value & csr_pkg::mtvec_wmask;
                csr_pkg::trap_sel_mepc:     mepc     <= wr_value & csr_pkg::mepc_wmask;
                csr_pkg::trap_sel_mcause:   mcause   <= wr_value;
                csr_pkg::trap_sel_mtval:    mtval    <= wr_value;
                csr_pkg::trap_sel_mscratch: mscratch <= wr_value;
                default: ;
            endcase
        end
    end

    // The mode field lives in the low two bits of mtvec and is not part of the base
    assign tvec_base  = {mtvec[31:2], 2'b00};
    assign vec_offset = {irq_cause[29:0], 2'b00};

    // Vectored mode only moves interrupts, exceptions always go to the base
    always_comb begin
        if (mtvec[0] && irq_ack) begin
            trap_target = tvec_base + vec_offset;
        end else begin
            trap_target = tvec_base;
        end
    end

    // The core takes an interrupt only when no exception is raised in that cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        !(exc.raise && irq_ack));

endmodule

/* list.f */
design/csr_pkg.sv
design/mstatus_reg.sv
design/trap_regs.sv
design/interrupt_ctrl.sv
design/csr_access.sv
design/csr_file.sv
tests/csr_file_tb.sv

/* tests/csr_file_tb.sv */
`timescale 1ns/10ps

module csr_file_tb;

    localparam int timeout_cycles = 16;

    typedef enum logic [2:0] {
        k_csr,
        k_exc,
        k_ack,
        k_mret,
        k_irq
    } step_kind_t;

    // One table row, and fields that a kind does not use stay zero
    typedef struct packed {
        step_kind_t       kind;
        csr_pkg::csr_op_t op;
        // CSR address, or the cause code of an exception
        logic [11:0]      addr;
        // Write data, the epc of a trap, or the irq lines in the low bits
        logic [31:0]      data;
        logic [31:0]      tval;
        // Expected rdata, expected target, or expected irq_pending in bit 0
        logic [31:0]      exp;
        logic             chk;
        logic             exp_ill;
    } step_t;

    logic                clk;
    logic                rst_n;
    csr_pkg::csr_req_t   req;
    csr_pkg::exc_t       exc;
    logic                irq_ack;
    logic                mret;
    logic [31:0]         irq_epc;
    csr_pkg::irq_lines_t irq;
    logic [31:0]         rdata;
    logic [31:0]         trap_target;
    logic [31:0]         mret_target;
    logic                illegal;
    logic                irq_pending;
    logic [1:0]          priv_mode;

    step_t steps[$];

    // Shadow copy of every CSR, kept by the architectural rules
    logic [31:0] m_mstatus;
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;
    logic [31:0] m_mscratch;
    logic [31:0] m_mie;
    // Lines as mip holds them, meip in bit 2 down to msip in bit 0
    logic [2:0]  m_lines;

    int errors;
    int checks;
    int tests;
    int failed_tests;
    int test_start_errors;

    // CSRs that random read-modify-write may reach
    logic [11:0] rw_csrs [5] = '{12'h300, 12'h305, 12'h341, 12'h340, 12'h304};
    logic [11:0] all_csrs [10] = '{12'h300, 12'h301, 12'h304, 12'h305, 12'h340,
                                   12'h341, 12'h342, 12'h343, 12'h344, 12'hF14};

    csr_file uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .exc         (exc),
        .irq_ack     (irq_ack),
        .mret        (mret),
        .irq_epc     (irq_epc),
        .irq         (irq),
        .rdata       (rdata),
        .trap_target (trap_target),
        .mret_target (mret_target),
        .illegal     (illegal),
        .irq_pending (irq_pending),
        .priv_mode   (priv_mode)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check32(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] mip_word();
        logic [31:0] w;
        w = 32'h0;
        w[11] = m_lines[2];
        w[7]  = m_lines[1];
        w[3]  = m_lines[0];
        return w;
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            12'h300: return m_mstatus;
            // MXL of 1 for RV32 and only the I extension bit
            12'h301: return 32'h4000_0100;
            12'h304: return m_mie;
            12'h305: return m_mtvec;
            12'h340: return m_mscratch;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'h343: return m_mtval;
            12'h344: return mip_word();
            default: return 32'h0;
        endcase
    endfunction

    // Each CSR keeps only its own writable bits
    task automatic model_write(input logic [11:0] addr, input logic [31:0] v);
        case (addr)
            12'h300: m_mstatus  = v & 32'h0000_19BB;
            12'h304: m_mie      = v & 32'h0000_0888;
            12'h305: m_mtvec    = v & 32'hFFFF_FFFD;
            12'h340: m_mscratch = v;
            12'h341: m_mepc     = v & 32'hFFFF_FFFC;
            12'h342: m_mcause   = v;
            12'h343: m_mtval    = v;
            default: ;
        endcase
    endtask

    task automatic model_trap(input logic [31:0] epc, input logic [31:0] cause,
                              input logic [31:0] tval);
        m_mstatus[7]     = m_mstatus[3];
        m_mstatus[3]     = 1'b0;
        m_mstatus[12:11] = 2'b11;
        m_mepc           = {epc[31:2], 2'b00};
        m_mcause         = cause;
        m_mtval          = tval;
    endtask

    // External first, then software, then timer
    function automatic logic [30:0] model_cause();
        logic [31:0] hit;
        hit = mip_word() & m_mie;
        if (hit[11])
            return 31'd11;
        else if (hit[3])
            return 31'd3;
        else
            return 31'd7;
    endfunction

    // Every strobe lasts one cycle, so each step starts by dropping them all
    task automatic next_cycle();
        @(posedge clk);
        req     <= '0;
        exc     <= '0;
        irq_ack <= 1'b0;
        mret    <= 1'b0;
    endtask

    task automatic csr_step(input csr_pkg::csr_op_t op, input logic [11:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp_rdata,
                            input logic chk, input logic exp_ill);
        logic [31:0] old;
        logic [31:0] nv;
        old = model_read(addr);
        next_cycle();
        req.valid <= 1'b1;
        req.op    <= op;
        req.addr  <= addr;
        req.wdata <= wdata;
        @(negedge clk);
        if (chk)
            check32("rdata", rdata, exp_rdata);
        check32("illegal", {31'h0, illegal}, {31'h0, exp_ill});
        check32("priv_mode", {30'h0, priv_mode}, 32'h3);
        // Set and clear with a zero operand only read
        if (!exp_ill && ((op == csr_pkg::op_rw) || (wdata != 32'h0))) begin
            case (op)
                csr_pkg::op_rs: nv = old | wdata;
                csr_pkg::op_rc: nv = old & ~wdata;
                default:        nv = wdata;
            endcase
            model_write(addr, nv);
        end
    endtask

    task automatic exc_step(input logic [30:0] cause, input logic [31:0] epc,
                            input logic [31:0] tval, input logic [31:0] exp_target);
        next_cycle();
        exc.raise <= 1'b1;
        exc.cause <= cause;
        exc.epc   <= epc;
        exc.tval  <= tval;
        @(negedge clk);
        check32("trap_target", trap_target, exp_target);
        model_trap(epc, {1'b0, cause}, tval);
    endtask

    task automatic ack_step(input logic [31:0] epc, input logic [31:0] exp_target);
        logic [30:0] cause;
        cause = model_cause();
        next_cycle();
        irq_ack <= 1'b1;
        irq_epc <= epc;
        @(negedge clk);
        check32("irq_pending", {31'h0, irq_pending}, 32'h1);
        check32("trap_target", trap_target, exp_target);
        model_trap(epc, {1'b1, cause}, 32'h0);
    endtask

    task automatic mret_step(input logic [31:0] exp_target);
        next_cycle();
        mret <= 1'b1;
        @(negedge clk);
        check32("mret_target", mret_target, exp_target);
        m_mstatus[3] = m_mstatus[7];
        m_mstatus[7] = 1'b1;
    endtask

    // Samples irq_pending on falling edges only, where it is settled
    task automatic wait_pending();
        int n;
        n = 0;
        @(negedge clk);
        while ((irq_pending !== 1'b1) && (n < timeout_cycles)) begin
            @(negedge clk);
            n++;
        end
        if (irq_pending !== 1'b1) begin
            $display("timeout: irq_pending did not rise within %0d cycles", timeout_cycles);
            errors++;
        end
    endtask

    task automatic irq_step(input logic [2:0] lines, input logic exp_pending);
        next_cycle();
        irq     <= lines;
        m_lines = lines;
        if (exp_pending) begin
            wait_pending();
        end else begin
            // mip registers the lines at the next rising edge, and the second
            // falling edge comes after it
            repeat (2) @(negedge clk);
            check32("irq_pending", {31'h0, irq_pending}, 32'h0);
        end
    endtask

    task automatic row_csr(input csr_pkg::csr_op_t op, input logic [11:0] addr,
                           input logic [31:0] data, input logic [31:0] exp,
                           input logic chk, input logic ill);
        steps.push_back('{k_csr, op, addr, data, 32'h0, exp, chk, ill});
    endtask

    task automatic row_evt(input step_kind_t kind, input logic [11:0] addr,
                           input logic [31:0] data, input logic [31:0] tval,
                           input logic [31:0] exp);
        steps.push_back('{kind, csr_pkg::op_rw, addr, data, tval, exp, 1'b0, 1'b0});
    endtask

    task automatic run_table();
        step_t s;
        while (steps.size() > 0) begin
            s = steps.pop_front();
            case (s.kind)
                k_csr:   csr_step(s.op, s.addr, s.data, s.exp, s.chk, s.exp_ill);
                k_exc:   exc_step({19'h0, s.addr}, s.data, s.tval, s.exp);
                k_ack:   ack_step(s.data, s.exp);
                k_mret:  mret_step(s.exp);
                k_irq:   irq_step(s.data[2:0], s.exp[0]);
                default: ;
            endcase
        end
    endtask

    // Reads every CSR and compares it with the shadow copy
    task automatic sweep_all();
        for (int i = 0; i < 10; i++)
            csr_step(csr_pkg::op_rs, all_csrs[i], 32'h0, model_read(all_csrs[i]), 1'b1, 1'b0);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        logic [11:0]      a;
        csr_pkg::csr_op_t op;
        logic [31:0]      d;
        void'($urandom(61947));
        rst_n   <= 1'b0;
        req     <= '0;
        exc     <= '0;
        irq_ack <= 1'b0;
        mret    <= 1'b0;
        irq_epc <= 32'h0;
        irq     <= '0;
        m_mstatus  = 32'h0000_1808;
        m_mtvec    = 32'h0;
        m_mepc     = 32'h0;
        m_mcause   = 32'h0;
        m_mtval    = 32'h0;
        m_mscratch = 32'h0;
        m_mie      = 32'h0;
        m_lines    = 3'b000;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        // Every CSR and status output starts at its reset value
        check32("irq_pending", {31'h0, irq_pending}, 32'h0);
        check32("priv_mode", {30'h0, priv_mode}, 32'h3);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mstatus, 32'h0, 32'h0000_1808, 1'b1, 1'b0);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_misa, 32'h0, 32'h4000_0100, 1'b1, 1'b0);
        for (int i = 2; i < 10; i++)
            row_csr(csr_pkg::op_rs, all_csrs[i], 32'h0, 32'h0, 1'b1, 1'b0);
        run_table();
        end_test("reset state");

        // Random set, clear and replace, each followed by a read back
        for (int i = 0; i < 40; i++) begin
            a  = rw_csrs[3'($urandom % 5)];
            op = csr_pkg::csr_op_t'(2'($urandom % 3));
            d  = $urandom;
            csr_step(op, a, d, model_read(a), 1'b1, 1'b0);
            csr_step(csr_pkg::op_rs, a, 32'h0, model_read(a), 1'b1, 1'b0);
        end
        sweep_all();
        end_test("random read-modify-write");

        row_csr(csr_pkg::op_rw, csr_pkg::csr_mtvec, 32'h0000_0100, 32'h0, 1'b0, 1'b0);
        row_csr(csr_pkg::op_rw, csr_pkg::csr_mstatus, 32'h0000_1808, 32'h0, 1'b0, 1'b0);
        row_evt(k_exc, 12'd2, 32'h0000_2003, 32'hDEAD_BEEF, 32'h0000_0100);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mepc, 32'h0, 32'h0000_2000, 1'b1, 1'b0);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mcause, 32'h0, 32'h0000_0002, 1'b1, 1'b0);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mtval, 32'h0, 32'hDEAD_BEEF, 1'b1, 1'b0);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mstatus, 32'h0, 32'h0000_1880, 1'b1, 1'b0);
        run_table();
        end_test("exception entry");

        row_evt(k_mret, 12'h0, 32'h0, 32'h0, 32'h0000_2000);
        row_csr(csr_pkg::op_rw, csr_pkg::csr_mstatus, 32'h0000_1800, 32'h0000_1888, 1'b1, 1'b0);
        row_evt(k_mret, 12'h0, 32'h0, 32'h0, 32'h0000_2000);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mstatus, 32'h0, 32'h0000_1880, 1'b1, 1'b0);
        run_table();
        end_test("mret");

        // Vectored base 0x200, so the target moves by four times the cause
        row_csr(csr_pkg::op_rw, csr_pkg::csr_mtvec, 32'h0000_0201, 32'h0000_0100, 1'b1, 1'b0);
        row_csr(csr_pkg::op_rw, csr_pkg::csr_mie, 32'h0000_0FFF, 32'h0, 1'b0, 1'b0);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mie, 32'h0, 32'h0000_0888, 1'b1, 1'b0);
        row_csr(csr_pkg::op_rw, csr_pkg::csr_mstatus, 32'h0000_1800, 32'h0000_1880, 1'b1, 1'b0);
        row_evt(k_irq, 12'h0, 32'h7, 32'h0, 32'h0);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mip, 32'h0, 32'h0000_0888, 1'b1, 1'b0);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mstatus, 32'h8, 32'h0000_1800, 1'b1, 1'b0);
        row_evt(k_irq, 12'h0, 32'h7, 32'h0, 32'h1);
        row_evt(k_ack, 12'h0, 32'h0000_3000, 32'h0, 32'h0000_022C);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mcause, 32'h0, 32'h8000_000B, 1'b1, 1'b0);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mepc, 32'h0, 32'h0000_3000, 1'b1, 1'b0);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mtval, 32'h0, 32'h0, 1'b1, 1'b0);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mstatus, 32'h0, 32'h0000_1880, 1'b1, 1'b0);
        // Trap entry cleared MIE, so nothing may be pending now
        row_evt(k_irq, 12'h0, 32'h3, 32'h0, 32'h0);
        row_evt(k_mret, 12'h0, 32'h0, 32'h0, 32'h0000_3000);
        row_evt(k_irq, 12'h0, 32'h3, 32'h0, 32'h1);
        row_evt(k_ack, 12'h0, 32'h0000_3104, 32'h0, 32'h0000_020C);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mcause, 32'h0, 32'h8000_0003, 1'b1, 1'b0);
        row_evt(k_mret, 12'h0, 32'h0, 32'h0, 32'h0000_3104);
        row_evt(k_irq, 12'h0, 32'h2, 32'h0, 32'h1);
        row_evt(k_ack, 12'h0, 32'h0000_3208, 32'h0, 32'h0000_021C);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mcause, 32'h0, 32'h8000_0007, 1'b1, 1'b0);
        row_csr(csr_pkg::op_rc, csr_pkg::csr_mie, 32'h0000_0080, 32'h0000_0888, 1'b1, 1'b0);
        row_evt(k_mret, 12'h0, 32'h0, 32'h0, 32'h0000_3208);
        row_evt(k_irq, 12'h0, 32'h2, 32'h0, 32'h0);
        row_evt(k_irq, 12'h0, 32'h0, 32'h0, 32'h0);
        run_table();
        end_test("interrupts");

        row_csr(csr_pkg::op_rs, 12'h7C0, 32'h0, 32'h0, 1'b0, 1'b1);
        row_csr(csr_pkg::op_rw, csr_pkg::csr_misa, 32'h0, 32'h0, 1'b0, 1'b1);
        row_csr(csr_pkg::op_rs, csr_pkg::csr_mhartid, 32'h1, 32'h0, 1'b0, 1'b1);
        row_csr(csr_pkg::op_rw, csr_pkg::csr_mip, 32'h0000_0888, 32'h0, 1'b0, 1'b1);
        row_csr(csr_pkg::op_rc, csr_pkg::csr_misa, 32'h0, 32'h4000_0100, 1'b1, 1'b0);
        run_table();
        sweep_all();
        end_test("illegal access");

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
